/* mem_pkg.sv */
package mem_pkg;

  localparam int XLEN          = 32;
  localparam int STRB_W        = XLEN / 8;
  localparam int LEN_W         = 8;    // AXI burst length field
  localparam int SIZE_W        = 4;    // one-hot byte count
  localparam int MEM_WORDS     = 256;
  localparam int MEM_AW        = $clog2(MEM_WORDS);
  localparam int MAX_BURST_LEN = 15;   // 16 beats at most

  // one-hot access size, 1/2/4/8 bytes
  localparam logic [SIZE_W-1:0] SIZE_1B = 4'b0001;
  localparam logic [SIZE_W-1:0] SIZE_2B = 4'b0010;
  localparam logic [SIZE_W-1:0] SIZE_4B = 4'b0100;
  localparam logic [SIZE_W-1:0] SIZE_8B = 4'b1000;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;
  localparam logic [2:0] AXI_PROT_DATA  = 3'b000;  // unprivileged, secure, data
  localparam logic [3:0] AXI_AWCACHE_WB = 4'b1111; // write-back, rw allocate
  localparam logic [3:0] AXI_ARCACHE_NC = 4'b0010; // normal, non-cacheable

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_ADDR_DATA,
    WR_ADDR,
    WR_DATA_VALID,
    WR_DATA_HS,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_RESP,
    S_READ
  } sram_state_e;

endpackage

/* axi_bus_if.sv */
`timescale 1ns/1ps

interface axi_bus_if import mem_pkg::*; ();

  // write address
  logic              aw_valid;
  logic              aw_ready;
  logic [XLEN-1:0]   aw_addr;
  logic [LEN_W-1:0]  aw_len;
  logic [2:0]        aw_size;
  logic [1:0]        aw_burst;
  logic [2:0]        aw_prot;
  logic [3:0]        aw_cache;

  // write data and response
  logic              w_valid;
  logic              w_ready;
  logic [XLEN-1:0]   w_data;
  logic [STRB_W-1:0] w_strb;
  logic              w_last;
  logic              b_valid;
  logic              b_ready;
  logic [1:0]        b_resp;

  // read address
  logic              ar_valid;
  logic              ar_ready;
  logic [XLEN-1:0]   ar_addr;
  logic [LEN_W-1:0]  ar_len;
  logic [2:0]        ar_size;
  logic [1:0]        ar_burst;
  logic [2:0]        ar_prot;
  logic [3:0]        ar_cache;

  // read data
  logic              r_valid;
  logic              r_ready;
  logic [XLEN-1:0]   r_data;
  logic [1:0]        r_resp;
  logic              r_last;

  modport master (
    output aw_valid, aw_addr, aw_len, aw_size, aw_burst, aw_prot, aw_cache,
    input  aw_ready,
    output w_valid, w_data, w_strb, w_last,
    input  w_ready,
    input  b_valid, b_resp,
    output b_ready,
    output ar_valid, ar_addr, ar_len, ar_size, ar_burst, ar_prot, ar_cache,
    input  ar_ready,
    input  r_valid, r_data, r_resp, r_last,
    output r_ready
  );

  modport slave (
    input  aw_valid, aw_addr, aw_len, aw_size, aw_burst, aw_prot, aw_cache,
    output aw_ready,
    input  w_valid, w_data, w_strb, w_last,
    output w_ready,
    output b_valid, b_resp,
    input  b_ready,
    input  ar_valid, ar_addr, ar_len, ar_size, ar_burst, ar_prot, ar_cache,
    output ar_ready,
    output r_valid, r_data, r_resp, r_last,
    input  r_ready
  );

endinterface

/* mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if import mem_pkg::*; ();

  // request, held until req_ready
  logic              req_valid;
  mem_op_e           op;
  logic [XLEN-1:0]   addr;
  logic [LEN_W-1:0]  len;
  logic [SIZE_W-1:0] size;
  logic [STRB_W-1:0] mask;
  logic [XLEN-1:0]   wdata;   // current write beat

  // bridge side
  logic              req_ready;
  logic [XLEN-1:0]   rdata;
  logic              rdata_valid;  // one pulse per read beat
  logic              rlast;
  logic              wbeat_ready;  // one pulse per write beat

  modport arbiter (
    output req_valid, op, addr, len, size, mask, wdata,
    input  req_ready, rdata, rdata_valid, rlast, wbeat_ready
  );

  modport bridge (
    input  req_valid, op, addr, len, size, mask, wdata,
    output req_ready, rdata, rdata_valid, rlast, wbeat_ready
  );

endinterface

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  // instruction fetch, read only
  input  logic              if_req_valid_i,
  input  logic [XLEN-1:0]   if_addr_i,
  input  logic [LEN_W-1:0]  if_len_i,
  output logic              if_req_ready_o,
  output logic [XLEN-1:0]   if_rdata_o,
  output logic              if_rdata_valid_o,
  output logic              if_rlast_o,
  // load/store
  input  logic              ls_req_valid_i,
  input  logic [XLEN-1:0]   ls_addr_i,
  input  logic [LEN_W-1:0]  ls_len_i,
  output logic              ls_req_ready_o,
  output logic [XLEN-1:0]   ls_rdata_o,
  output logic              ls_rdata_valid_o,
  output logic              ls_rlast_o,
  input  mem_op_e           ls_op_i,
  input  logic [SIZE_W-1:0] ls_size_i,
  input  logic [STRB_W-1:0] ls_mask_i,
  input  logic [XLEN-1:0]   ls_wdata_i,
  output logic              ls_wbeat_ready_o,
  mem_req_if.arbiter        req
);

  logic busy;      // transaction in flight
  logic owner;     // 1 = load/store owns the bus or was served last
  logic pick_ls;
  logic route_ls;
  logic accept;
  logic done;

  // round robin where the client not served last wins a tie
  always_comb begin
    if (if_req_valid_i && ls_req_valid_i) begin
      pick_ls = !owner;
    end else begin
      pick_ls = ls_req_valid_i;
    end
  end

  assign route_ls = busy ? owner : pick_ls;  // hold the winner's fields
  assign accept   = req.req_valid && req.req_ready;
  assign done     = busy && req.req_ready;   // bridge back to idle

  assign req.req_valid = !busy && (if_req_valid_i || ls_req_valid_i);
  assign req.op        = route_ls ? ls_op_i : OP_READ;
  assign req.addr      = route_ls ? ls_addr_i : if_addr_i;
  assign req.len       = route_ls ? ls_len_i : if_len_i;
  assign req.size      = route_ls ? ls_size_i : SIZE_4B;  // fetch is a full word
  assign req.mask      = route_ls ? ls_mask_i : {STRB_W{1'b1}};
  assign req.wdata     = ls_wdata_i;  // only load/store writes

  assign if_req_ready_o = !busy && if_req_valid_i && !pick_ls && req.req_ready;
  assign ls_req_ready_o = !busy && pick_ls && req.req_ready;

  // returning beats go to the owner only
  assign if_rdata_o       = req.rdata;
  assign if_rdata_valid_o = req.rdata_valid && !owner;
  assign if_rlast_o       = req.rlast && !owner;
  assign ls_rdata_o       = req.rdata;
  assign ls_rdata_valid_o = req.rdata_valid && owner;
  assign ls_rlast_o       = req.rlast && owner;
  assign ls_wbeat_ready_o = req.wbeat_ready && owner;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      owner <= 1'b0;
    end else if (accept) begin
      busy  <= 1'b1;
      owner <= pick_ls;
    end else if (done) begin
      busy  <= 1'b0;  // the other client has priority next
    end
  end

  // grant and owner stay put until the final read beat or write pulse
  owner_held_a: assert property (@(posedge clock) disable iff (reset)
    busy && !req.rlast && !req.wbeat_ready |=> busy && $stable(owner));

  len_max_a: assert property (@(posedge clock) disable iff (reset)
    (if_req_valid_i |-> if_len_i <= MAX_BURST_LEN) and
    (ls_req_valid_i |-> ls_len_i <= MAX_BURST_LEN));

  // the bridge only answers a transaction this arbiter issued
  resp_owned_a: assert property (@(posedge clock) disable iff (reset)
    (req.rdata_valid || req.wbeat_ready) |-> busy);

endmodule

/* axi4_rw.sv */
`timescale 1ns/1ps

module axi4_rw import mem_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  mem_req_if.bridge  req,
  axi_bus_if.master  axi
);

  rd_state_e        rd_state;
  wr_state_e        wr_state;
  logic [2:0]       size_code;
  logic [LEN_W-1:0] beat_cnt;  // write beats done
  logic             rd_start;
  logic             wr_start;
  logic             ar_hs;
  logic             aw_hs;
  logic             w_hs;
  logic             r_hs;
  logic             b_hs;

  assign ar_hs = axi.ar_valid && axi.ar_ready;
  assign aw_hs = axi.aw_valid && axi.aw_ready;
  assign w_hs  = axi.w_valid && axi.w_ready;
  assign r_hs  = axi.r_valid && axi.r_ready;
  assign b_hs  = axi.b_valid && axi.b_ready;

  assign req.req_ready = (rd_state == RD_IDLE) && (wr_state == WR_IDLE);
  assign rd_start = req.req_valid && req.req_ready && (req.op == OP_READ);
  assign wr_start = req.req_valid && req.req_ready && (req.op == OP_WRITE);

  // one-hot bytes to AXI size code
  always_comb begin
    case (req.size)
      SIZE_1B: size_code = 3'd0;
      SIZE_2B: size_code = 3'd1;
      SIZE_8B: size_code = 3'd3;
      default: size_code = 3'd2;  // word
    endcase
  end

  assign axi.ar_burst = AXI_BURST_INCR;
  assign axi.ar_prot  = AXI_PROT_DATA;
  assign axi.ar_cache = AXI_ARCACHE_NC;
  assign axi.aw_burst = AXI_BURST_INCR;
  assign axi.aw_prot  = AXI_PROT_DATA;
  assign axi.aw_cache = AXI_AWCACHE_WB;
  assign axi.w_data   = req.wdata;  // client holds the beat until wbeat_ready

  // captured request fields and read data
  always_ff @(posedge clock) begin
    if (rd_start) begin
      axi.ar_addr <= req.addr;
      axi.ar_len  <= req.len;
      axi.ar_size <= size_code;
    end
    if (wr_start) begin
      axi.aw_addr <= req.addr;
      axi.aw_len  <= req.len;
      axi.aw_size <= size_code;
      axi.w_strb  <= req.mask;
      beat_cnt    <= '0;
    end else if (w_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
    if (r_hs) begin
      req.rdata <= axi.r_data;
    end
  end

  // read engine
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state        <= RD_IDLE;
      axi.ar_valid    <= 1'b0;
      axi.r_ready     <= 1'b0;
      req.rdata_valid <= 1'b0;
      req.rlast       <= 1'b0;
    end else begin
      req.rdata_valid <= 1'b0;  // single-cycle pulses
      req.rlast       <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (rd_start) begin
            axi.ar_valid <= 1'b1;
            rd_state     <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (ar_hs) begin
            axi.ar_valid <= 1'b0;
            axi.r_ready  <= 1'b1;
            rd_state     <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (r_hs) begin
            req.rdata_valid <= 1'b1;
            if (axi.r_last) begin
              req.rlast   <= 1'b1;
              axi.r_ready <= 1'b0;
              rd_state    <= RD_IDLE;
            end
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // write engine
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state        <= WR_IDLE;
      axi.aw_valid    <= 1'b0;
      axi.w_valid     <= 1'b0;
      axi.w_last      <= 1'b0;
      axi.b_ready     <= 1'b0;
      req.wbeat_ready <= 1'b0;
    end else begin
      req.wbeat_ready <= 1'b0;
      case (wr_state)
        WR_IDLE: begin
          if (wr_start) begin
            axi.aw_valid <= 1'b1;
            axi.b_ready  <= 1'b1;
            if (req.len == '0) begin  // single beat, AW and W together
              axi.w_valid <= 1'b1;
              axi.w_last  <= 1'b1;
              wr_state    <= WR_ADDR_DATA;
            end else begin
              wr_state <= WR_ADDR;
            end
          end
        end
        WR_ADDR_DATA: begin
          if (aw_hs) begin
            axi.aw_valid <= 1'b0;
          end
          if (w_hs) begin
            axi.w_valid <= 1'b0;
            axi.w_last  <= 1'b0;
          end
          if (b_hs) begin
            axi.b_ready     <= 1'b0;
            req.wbeat_ready <= 1'b1;
            wr_state        <= WR_IDLE;
          end
        end
        WR_ADDR: begin
          if (aw_hs) begin
            axi.aw_valid <= 1'b0;
            wr_state     <= WR_DATA_VALID;
          end
        end
        WR_DATA_VALID: begin
          axi.w_valid <= 1'b1;
          axi.w_last  <= (beat_cnt == axi.aw_len);
          wr_state    <= WR_DATA_HS;
        end
        WR_DATA_HS: begin
          if (w_hs) begin
            axi.w_valid <= 1'b0;
            axi.w_last  <= 1'b0;
            if (axi.w_last) begin
              wr_state <= WR_RESP;  // last pulse waits for B
            end else begin
              req.wbeat_ready <= 1'b1;
              wr_state        <= WR_DATA_VALID;
            end
          end
        end
        WR_RESP: begin
          if (b_hs) begin
            axi.b_ready     <= 1'b0;
            req.wbeat_ready <= 1'b1;
            wr_state        <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  ar_hold_a: assert property (@(posedge clock) disable iff (reset)
    axi.ar_valid && !axi.ar_ready |=> axi.ar_valid && $stable(axi.ar_addr));

  aw_hold_a: assert property (@(posedge clock) disable iff (reset)
    axi.aw_valid && !axi.aw_ready |=> axi.aw_valid && $stable(axi.aw_addr));

  len_max_a: assert property (@(posedge clock) disable iff (reset)
    (rd_start || wr_start) |-> req.len <= MAX_BURST_LEN);

  // no error path here, the slave must answer OKAY
  resp_okay_a: assert property (@(posedge clock) disable iff (reset)
    (axi.r_valid |-> axi.r_resp == AXI_RESP_OKAY) and
    (axi.b_valid |-> axi.b_resp == AXI_RESP_OKAY));

endmodule

/* axi_sram.sv */
`timescale 1ns/1ps

module axi_sram import mem_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  axi_bus_if.slave  axi
);

  logic [XLEN-1:0]   mem [MEM_WORDS];
  sram_state_e       state;
  logic [MEM_AW-1:0] ptr;  // word under the current beat
  logic [LEN_W-1:0]  cnt;  // beats left after this one
  logic              ar_hs;
  logic              aw_hs;
  logic              w_hs;
  logic              r_hs;
  logic              b_hs;

  assign ar_hs = axi.ar_valid && axi.ar_ready;
  assign aw_hs = axi.aw_valid && axi.aw_ready;
  assign w_hs  = axi.w_valid && axi.w_ready;
  assign r_hs  = axi.r_valid && axi.r_ready;
  assign b_hs  = axi.b_valid && axi.b_ready;

  assign axi.ar_ready = (state == S_IDLE);
  assign axi.aw_ready = (state == S_IDLE) && !axi.ar_valid;  // reads first
  assign axi.w_ready  = (state == S_WRITE);
  assign axi.b_valid  = (state == S_RESP);
  assign axi.b_resp   = AXI_RESP_OKAY;
  assign axi.r_valid  = (state == S_READ);
  assign axi.r_data   = mem[ptr];
  assign axi.r_resp   = AXI_RESP_OKAY;
  assign axi.r_last   = (state == S_READ) && (cnt == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (ar_hs) begin
            state <= S_READ;
          end else if (aw_hs) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (w_hs && cnt == '0) begin
            state <= S_RESP;
          end
        end
        S_RESP: begin
          if (b_hs) begin
            state <= S_IDLE;
          end
        end
        S_READ: begin
          if (r_hs && cnt == '0) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // burst address and count
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      ptr <= axi.ar_addr[MEM_AW+1:2];
      cnt <= axi.ar_len;
    end else if (aw_hs) begin
      ptr <= axi.aw_addr[MEM_AW+1:2];
      cnt <= axi.aw_len;
    end else if (w_hs || r_hs) begin
      ptr <= ptr + 1'b1;  // wraps at MEM_WORDS
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (w_hs) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axi.w_strb[b]) begin
          mem[ptr][8*b +: 8] <= axi.w_data[8*b +: 8];
        end
      end
    end
  end

  // INCR only, data access, beat no wider than the bus
  aw_attr_a: assert property (@(posedge clock) disable iff (reset)
    aw_hs |-> axi.aw_burst == AXI_BURST_INCR && axi.aw_prot == AXI_PROT_DATA
              && axi.aw_size <= 3'd2 && axi.aw_cache[1]);

  ar_attr_a: assert property (@(posedge clock) disable iff (reset)
    ar_hs |-> axi.ar_burst == AXI_BURST_INCR && axi.ar_prot == AXI_PROT_DATA
              && axi.ar_size <= 3'd2 && axi.ar_cache[1]);

  // master's w_last must agree with the length given on AW
  wlast_a: assert property (@(posedge clock) disable iff (reset)
    w_hs |-> axi.w_last == (cnt == '0));

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  // instruction fetch
  input  logic              if_req_valid_i,
  input  logic [XLEN-1:0]   if_addr_i,
  input  logic [LEN_W-1:0]  if_len_i,
  output logic              if_req_ready_o,
  output logic [XLEN-1:0]   if_rdata_o,
  output logic              if_rdata_valid_o,
  output logic              if_rlast_o,
  // load/store
  input  logic              ls_req_valid_i,
  input  logic [XLEN-1:0]   ls_addr_i,
  input  logic [LEN_W-1:0]  ls_len_i,
  output logic              ls_req_ready_o,
  output logic [XLEN-1:0]   ls_rdata_o,
  output logic              ls_rdata_valid_o,
  output logic              ls_rlast_o,
  input  mem_op_e           ls_op_i,
  input  logic [SIZE_W-1:0] ls_size_i,
  input  logic [STRB_W-1:0] ls_mask_i,
  input  logic [XLEN-1:0]   ls_wdata_i,
  output logic              ls_wbeat_ready_o
);

  mem_req_if i_req_if ();
  axi_bus_if i_axi_if ();

  mem_arbiter i_arbiter (
    .clock,
    .reset,
    .if_req_valid_i,
    .if_addr_i,
    .if_len_i,
    .if_req_ready_o,
    .if_rdata_o,
    .if_rdata_valid_o,
    .if_rlast_o,
    .ls_req_valid_i,
    .ls_addr_i,
    .ls_len_i,
    .ls_req_ready_o,
    .ls_rdata_o,
    .ls_rdata_valid_o,
    .ls_rlast_o,
    .ls_op_i,
    .ls_size_i,
    .ls_mask_i,
    .ls_wdata_i,
    .ls_wbeat_ready_o,
    .req              (i_req_if.arbiter)
  );

  axi4_rw i_bridge (
    .clock,
    .reset,
    .req   (i_req_if.bridge),
    .axi   (i_axi_if.master)
  );

  axi_sram i_sram (
    .clock,
    .reset,
    .axi   (i_axi_if.slave)
  );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;   // after the rising edge
  localparam int RESET_CYCLES = 10;
  localparam int N_MASK       = 20;
  localparam int N_FETCH      = 20;
  localparam int N_CONC       = 12;
  // worst case beat count over all phases
  localparam int MAX_BEATS    = 2 * MEM_WORDS + 2 * N_MASK + 16 * N_FETCH
                                + 32 * N_CONC + 48;
  localparam int TIMEOUT_CYCLES = MAX_BEATS * 20 + 500;

  logic              clock;
  logic              reset;
  logic              if_req_valid_i;
  logic [XLEN-1:0]   if_addr_i;
  logic [LEN_W-1:0]  if_len_i;
  logic              if_req_ready_o;
  logic [XLEN-1:0]   if_rdata_o;
  logic              if_rdata_valid_o;
  logic              if_rlast_o;
  logic              ls_req_valid_i;
  logic [XLEN-1:0]   ls_addr_i;
  logic [LEN_W-1:0]  ls_len_i;
  logic              ls_req_ready_o;
  logic [XLEN-1:0]   ls_rdata_o;
  logic              ls_rdata_valid_o;
  logic              ls_rlast_o;
  mem_op_e           ls_op_i;
  logic [SIZE_W-1:0] ls_size_i;
  logic [STRB_W-1:0] ls_mask_i;
  logic [XLEN-1:0]   ls_wdata_i;
  logic              ls_wbeat_ready_o;

  logic [XLEN-1:0] model [MEM_WORDS];  // expected memory contents
  int if_done;  // completed fetch transactions
  int ls_done;  // completed load/store transactions

  mem_subsys_top i_dut (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_rdata(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string name);
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s expected %08h actual %08h", name, exp, got));
    end
  endtask

  task automatic check_rlast(input logic got, input int beat, input int last_beat,
                             input string name);
    logic exp;
    exp = (beat == last_beat);
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s rlast at beat %0d expected %0b actual %0b",
                             name, beat, exp, got));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s expected %0b actual %0b", name, exp, got));
    end
  endtask

  task automatic check_idle_outputs(input string name);
    check_flag(if_req_ready_o, 1'b0, {name, " if_req_ready"});
    check_flag(if_rdata_valid_o, 1'b0, {name, " if_rdata_valid"});
    check_flag(if_rlast_o, 1'b0, {name, " if_rlast"});
    check_flag(ls_req_ready_o, 1'b0, {name, " ls_req_ready"});
    check_flag(ls_rdata_valid_o, 1'b0, {name, " ls_rdata_valid"});
    check_flag(ls_rlast_o, 1'b0, {name, " ls_rlast"});
    check_flag(ls_wbeat_ready_o, 1'b0, {name, " ls_wbeat_ready"});
  endtask

  // byte lanes follow the mask, word index wraps at the memory depth
  task automatic model_write(input int word, input logic [XLEN-1:0] data,
                             input logic [STRB_W-1:0] mask);
    for (int b = 0; b < STRB_W; b++) begin
      if (mask[b]) begin
        model[word % MEM_WORDS][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  function automatic int rand_len(input int start, input int top);
    int len;
    len = $urandom_range(MAX_BURST_LEN, 0);
    if (start + len > top) begin
      len = top - start;
    end
    return len;
  endfunction

  task automatic fetch_read(input int start, input int len, input string name);
    int beat;
    int ls_seen;
    @(posedge clock);
    #DRIVE_DLY;
    if_req_valid_i = 1'b1;
    if_addr_i      = XLEN'(start * 4);
    if_len_i       = LEN_W'(len);
    ls_seen        = ls_done;
    @(negedge clock);
    while (!if_req_ready_o) @(negedge clock);
    if (ls_done - ls_seen > 1) begin
      report_error($sformatf("%s: fetch waited through %0d load/store transactions",
                             name, ls_done - ls_seen));
    end
    @(posedge clock);
    #DRIVE_DLY;
    if_req_valid_i = 1'b0;
    beat = 0;
    while (beat <= len) begin
      @(negedge clock);
      if (if_rdata_valid_o) begin
        check_rdata(if_rdata_o, model[(start + beat) % MEM_WORDS],
                    $sformatf("%s word %0d", name, (start + beat) % MEM_WORDS));
        check_rlast(if_rlast_o, beat, len, name);
        beat++;
      end
    end
    if_done++;
  endtask

  task automatic ls_read(input int start, input int len, input string name);
    int beat;
    int if_seen;
    @(posedge clock);
    #DRIVE_DLY;
    ls_req_valid_i = 1'b1;
    ls_op_i        = OP_READ;
    ls_addr_i      = XLEN'(start * 4);
    ls_len_i       = LEN_W'(len);
    ls_size_i      = SIZE_4B;
    if_seen        = if_done;
    @(negedge clock);
    while (!ls_req_ready_o) @(negedge clock);
    if (if_done - if_seen > 1) begin
      report_error($sformatf("%s: load/store waited through %0d fetch transactions",
                             name, if_done - if_seen));
    end
    @(posedge clock);
    #DRIVE_DLY;
    ls_req_valid_i = 1'b0;
    beat = 0;
    while (beat <= len) begin
      @(negedge clock);
      if (ls_rdata_valid_o) begin
        check_rdata(ls_rdata_o, model[(start + beat) % MEM_WORDS],
                    $sformatf("%s word %0d", name, (start + beat) % MEM_WORDS));
        check_rlast(ls_rlast_o, beat, len, name);
        beat++;
      end
    end
    ls_done++;
  endtask

  task automatic ls_write(input int start, input int len, input logic [STRB_W-1:0] mask,
                          input string name);
    logic [XLEN-1:0] data [16];
    int beat;
    int if_seen;
    for (int i = 0; i <= len; i++) begin
      data[i] = $urandom;
    end
    @(posedge clock);
    #DRIVE_DLY;
    ls_req_valid_i = 1'b1;
    ls_op_i        = OP_WRITE;
    ls_addr_i      = XLEN'(start * 4);
    ls_len_i       = LEN_W'(len);
    ls_size_i      = SIZE_4B;
    ls_mask_i      = mask;
    ls_wdata_i     = data[0];
    if_seen        = if_done;
    @(negedge clock);
    while (!ls_req_ready_o) @(negedge clock);
    if (if_done - if_seen > 1) begin
      report_error($sformatf("%s: load/store waited through %0d fetch transactions",
                             name, if_done - if_seen));
    end
    @(posedge clock);
    #DRIVE_DLY;
    ls_req_valid_i = 1'b0;
    beat = 0;
    while (beat <= len) begin
      @(negedge clock);
      if (ls_wbeat_ready_o) begin
        model_write(start + beat, data[beat], mask);
        beat++;
        if (beat <= len) begin
          @(posedge clock);
          #DRIVE_DLY;
          ls_wdata_i = data[beat];  // next beat once the last one is taken
        end
      end
    end
    ls_done++;
  endtask

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    report_error($sformatf("timeout: transactions did not finish within %0d cycles",
                           TIMEOUT_CYCLES));
  end

  initial begin
    int word;
    int len;
    clock          = 1'b0;
    reset          = 1'b1;
    if_req_valid_i = 1'b0;
    if_addr_i      = '0;
    if_len_i       = '0;
    ls_req_valid_i = 1'b0;
    ls_addr_i      = '0;
    ls_len_i       = '0;
    ls_op_i        = OP_READ;
    ls_size_i      = SIZE_4B;
    ls_mask_i      = '0;
    ls_wdata_i     = '0;
    if_done        = 0;
    ls_done        = 0;
    void'($urandom(32'h9bb9035c));

    repeat (RESET_CYCLES - 1) begin
      @(negedge clock);
      check_idle_outputs("in reset");
    end
    @(posedge clock);
    #DRIVE_DLY;
    reset = 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_idle_outputs("after reset");
    end

    // preload with full masks, then read everything back
    word = 0;
    while (word < MEM_WORDS) begin
      len = rand_len(word, MEM_WORDS - 1);
      ls_write(word, len, {STRB_W{1'b1}}, "preload write");
      word += len + 1;
    end
    word = 0;
    while (word < MEM_WORDS) begin
      len = rand_len(word, MEM_WORDS - 1);
      ls_read(word, len, "preload read");
      word += len + 1;
    end

    repeat (N_MASK) begin
      word = $urandom_range(MEM_WORDS - 1, MEM_WORDS / 2);
      ls_write(word, 0, STRB_W'($urandom), "byte mask write");
      ls_read(word, 0, "byte mask read");
    end

    repeat (N_FETCH) begin
      word = $urandom_range(MEM_WORDS / 2 - 1, 0);
      fetch_read(word, rand_len(word, MEM_WORDS / 2 - 1), "fetch burst");
    end

    // both clients at once, fetch low half and load/store high half
    fork
      begin : fetch_side
        int f_word;
        repeat (N_CONC) begin
          f_word = $urandom_range(MEM_WORDS / 2 - 1, 0);
          fetch_read(f_word, rand_len(f_word, MEM_WORDS / 2 - 1), "arbitration fetch");
        end
      end
      begin : ls_side
        int l_word;
        repeat (N_CONC) begin
          l_word = $urandom_range(MEM_WORDS - 1, MEM_WORDS / 2);
          if ($urandom_range(1, 0) == 1) begin
            ls_write(l_word, rand_len(l_word, MEM_WORDS - 1), STRB_W'($urandom),
                     "arbitration write");
          end else begin
            ls_read(l_word, rand_len(l_word, MEM_WORDS - 1), "arbitration read");
          end
        end
      end
    join

    // burst across the top word
    ls_write(MEM_WORDS - 6, MAX_BURST_LEN, {STRB_W{1'b1}}, "wrap write");
    ls_read(MEM_WORDS - 6, MAX_BURST_LEN, "wrap read");
    fetch_read(0, 9, "wrap fetch");

    $display("TEST OK");
    $finish;
  end

endmodule

/* vlog.f */
mem_pkg.sv
axi_bus_if.sv
mem_req_if.sv
mem_arbiter.sv
axi4_rw.sv
axi_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - axi_bus_if.sv
  - mem_req_if.sv
  - mem_arbiter.sv
  - axi4_rw.sv
  - axi_sram.sv
  - mem_subsys_top.sv
  - target: test
    files:
      - tb_mem_subsys.sv
